// File: sim.f
design/fpu_ops_pkg.sv
design/fpu_data_pkg.sv
design/fp_simd_lane.sv
design/fp_to_int_cvt.sv
design/fpu_simd_cluster.sv
test/fpu_simd_cluster_sva.sv
test/tb_fpu_simd_cluster.sv

// File: Bender.yml
package:
  name: fpu_simd_cluster

sources:
  - design/fpu_ops_pkg.sv
  - design/fpu_data_pkg.sv
  - design/fp_simd_lane.sv
  - design/fp_to_int_cvt.sv
  - design/fpu_simd_cluster.sv
  - target: test
    files:
      - test/fpu_simd_cluster_sva.sv
      - test/tb_fpu_simd_cluster.sv

// File: test/tb_fpu_simd_cluster.sv
/*
  FPU SIMD cluster testbench
  Random issues on all three lanes, checked every cycle against a model
  of the held results, the forwarding bus and the float to int converter.
*/
`timescale 1ns/1ps

module tb_fpu_simd_cluster
  import fpu_ops_pkg::*;
  import fpu_data_pkg::*;
();

  localparam int     CVT_STAGES  = 2;
  localparam int     RST_CYCLES  = 2;
  localparam int     NUM_ISSUES  = 400;
  localparam int     RUN_CYCLES  = NUM_ISSUES + CVT_STAGES + 2;
  localparam longint WATCHDOG_NS = (RST_CYCLES + RUN_CYCLES + CVT_STAGES + 20) * 100;

  logic           clk;
  logic           rst_n;
  vec_t     [2:0] a_in;
  vec_t     [2:0] b_in;
  src_sel_t [2:0] src_a_in;
  src_sel_t [2:0] src_b_in;
  fp_op_t   [2:0] op_in;
  logic     [2:0] en_in;
  vec_t     [2:0] res_out;
  logic     [2:0] res_valid_out;
  vec_t           cvt_res;
  logic           cvt_valid;

  integer     seed;
  vec_t       held [3];
  vec_t       held_seen [3];
  logic [2:0] exp_valid;
  logic [2:0] exp_valid_next;
  logic       cvt_q_valid [$];
  vec_t       cvt_q_data [$];

  fpu_simd_cluster #(
    .CVT_STAGES (CVT_STAGES)
  ) uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .l0_a         (a_in[0]),
    .l0_b         (b_in[0]),
    .l0_src_a     (src_a_in[0]),
    .l0_src_b     (src_b_in[0]),
    .l0_op        (op_in[0]),
    .l0_en        (en_in[0]),
    .l0_res       (res_out[0]),
    .l0_res_valid (res_valid_out[0]),
    .l1_a         (a_in[1]),
    .l1_b         (b_in[1]),
    .l1_src_a     (src_a_in[1]),
    .l1_src_b     (src_b_in[1]),
    .l1_op        (op_in[1]),
    .l1_en        (en_in[1]),
    .l1_res       (res_out[1]),
    .l1_res_valid (res_valid_out[1]),
    .l2_a         (a_in[2]),
    .l2_b         (b_in[2]),
    .l2_src_a     (src_a_in[2]),
    .l2_src_b     (src_b_in[2]),
    .l2_op        (op_in[2]),
    .l2_en        (en_in[2]),
    .l2_res       (res_out[2]),
    .l2_res_valid (res_valid_out[2]),
    .cvt_res      (cvt_res),
    .cvt_valid    (cvt_valid)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  ////////////////////////////////////////
  // Stimulus and reference model

  // Biased toward zeros, infinities, NaNs, the int32 edges and denormals
  function automatic single_t rand_single();
    logic [31:0] r;
    single_t     v;
    r = $random(seed);
    case ($unsigned($random(seed)) % 12)
      0:       v = 32'h0000_0000;
      1:       v = 32'h8000_0000;
      2:       v = {r[31], 8'hFF, 23'h0};
      3:       v = {r[31], 8'hFF, r[22:1], 1'b1};
      4:       v = {r[31], 8'h9E, 21'h0, r[1:0]};
      5:       v = {r[31], 8'h9D, r[22:0]};
      6:       v = 32'hCF00_0000;
      7:       v = {r[31], 8'h00, r[22:0]};
      8, 9:    v = {r[31], 8'd118 + {3'b0, r[27:23]}, r[22:0]};
      default: v = r;
    endcase
    return v;
  endfunction

  // Strict sign-magnitude order with minus zero below plus zero
  function automatic logic orders_below(single_t x, single_t y);
    if (x[31] != y[31])
      return x[31];
    if (x[31])
      return x[30:0] > y[30:0];
    return x[30:0] < y[30:0];
  endfunction

  function automatic single_t model_elem(fp_op_t op, single_t x, single_t y);
    case (op)
      OP_MIN:  return orders_below(y, x) ? y : x;
      OP_MAX:  return orders_below(x, y) ? y : x;
      OP_NEG:  return x ^ 32'h8000_0000;
      default: return x & 32'h7FFF_FFFF;
    endcase
  endfunction

  function automatic vec_t model_lane(fp_op_t op, vec_t x, vec_t y);
    case (op)
      OP_AND:  return x & y;
      OP_OR:   return x | y;
      OP_XOR:  return x ^ y;
      OP_ANDN: return x & ~y;
      default: return {model_elem(op, x[63:32], y[63:32]), model_elem(op, x[31:0], y[31:0])};
    endcase
  endfunction

  function automatic int32_t model_cvt(single_t x);
    int     e;
    longint mag;
    e = int'(x[30:23]) - 127;
    if (x[30:23] == 8'hFF && x[22:0] != 23'h0)
      return 0;
    // Denormals and magnitudes below one truncate to zero
    if (e < 0)
      return 0;
    if (e >= 31)
      return x[31] ? INT_MIN_C : INT_MAX_C;
    mag = longint'({1'b1, x[22:0]});
    mag = (e >= 23) ? (mag << (e - 23)) : (mag >> (23 - e));
    return x[31] ? int32_t'(-mag) : int32_t'(mag);
  endfunction

  function automatic vec_t model_src(src_sel_t s, vec_t port);
    return (s == SRC_PORT) ? port : held[s - 1];
  endfunction

  task automatic issue_cycle(input int idx);
    vec_t     nxt [3];
    vec_t     a;
    vec_t     b;
    fp_op_t   op;
    src_sel_t sa;
    src_sel_t sb;
    logic     en;
    logic     cv;
    vec_t     cd;
    vec_t     ca;
    cv = 1'b0;
    cd = '0;
    for (int n = 0; n < 3; n++) begin
      nxt[n] = held[n];
      a = {rand_single(), rand_single()};
      b = {rand_single(), rand_single()};
      case ($unsigned($random(seed)) % 8)
        0:       b = a;
        1:       b[31:0] = a[31:0];
        default: b = b;
      endcase
      en = ($unsigned($random(seed)) % 4) != 0;
      op = fp_op_t'($unsigned($random(seed)) % 9);
      sa = src_sel_t'($random(seed));
      sb = src_sel_t'($random(seed));
      if (idx == 0) begin
        // First issue reads the other lanes straight out of reset
        en = 1'b1;
        op = OP_OR;
        sa = src_sel_t'((n + 1) % 3 + 1);
        sb = src_sel_t'((n + 2) % 3 + 1);
      end else if (idx >= NUM_ISSUES) begin
        en = 1'b0;
      end
      a_in[n]     <= a;
      b_in[n]     <= b;
      src_a_in[n] <= sa;
      src_b_in[n] <= sb;
      op_in[n]    <= op;
      en_in[n]    <= en;
      exp_valid_next[n] = en && (op != OP_CVT);
      if (en && op != OP_CVT)
        nxt[n] = model_lane(op, model_src(sa, a), model_src(sb, b));
      if (en && op == OP_CVT && n == 2) begin
        cv = 1'b1;
        ca = model_src(sa, a);
        cd = {model_cvt(ca[63:32]), model_cvt(ca[31:0])};
      end
    end
    cvt_q_valid.push_back(cv);
    cvt_q_data.push_back(cd);
    for (int n = 0; n < 3; n++)
      held[n] = nxt[n];
  endtask

  ////////////////////////////////////////
  // Checks

  task automatic check_outputs();
    logic cv;
    vec_t cd;
    for (int n = 0; n < 3; n++) begin
      assert (res_valid_out[n] === exp_valid[n]) else
        fail_run($sformatf("Lane %0d result valid %s", n,
                           exp_valid[n] ? "is missing" : "rose without an issue"));
      assert (res_out[n] === held_seen[n]) else
        fail_run($sformatf("** Error: l%0d_res expected 0x%h, actual 0x%h",
                           n, held_seen[n], res_out[n]));
    end
    cv = cvt_q_valid.pop_front();
    cd = cvt_q_data.pop_front();
    assert (cvt_valid === cv) else
      fail_run(cv ? "Conversion valid is missing" : "Conversion valid rose without an issue");
    if (cv) begin
      assert (cvt_res === cd) else
        fail_run($sformatf("** Error: cvt_res expected 0x%h, actual 0x%h", cd, cvt_res));
    end
  endtask

  initial begin
    seed  = 76654;
    rst_n = 1'b0;
    en_in = '0;
    exp_valid      = '0;
    exp_valid_next = '0;
    for (int n = 0; n < 3; n++) begin
      a_in[n]     = '0;
      b_in[n]     = '0;
      src_a_in[n] = SRC_PORT;
      src_b_in[n] = SRC_PORT;
      op_in[n]    = OP_AND;
      held[n]     = '0;
    end
    repeat (CVT_STAGES) begin
      cvt_q_valid.push_back(1'b0);
      cvt_q_data.push_back('0);
    end
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (res_valid_out === 3'b000 && cvt_valid === 1'b0) else
      fail_run("A result valid is high after reset");
    for (int i = 0; i < RUN_CYCLES; i++) begin
      @(posedge clk);
      for (int n = 0; n < 3; n++)
        held_seen[n] = held[n];
      exp_valid = exp_valid_next;
      issue_cycle(i);
      @(negedge clk);
      check_outputs();
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    fail_run("Watchdog expired before the test sequence completed");
  end

endmodule

// File: test/fpu_simd_cluster_sva.sv
/*
  FPU SIMD cluster timing checks
  Reset state, lane and converter enable to valid latency
*/
`timescale 1ns/1ps

module fpu_simd_cluster_sva
  import fpu_ops_pkg::*;
#(
  parameter int CVT_STAGES = 2
) (
  input logic   clk,
  input logic   rst_n,
  input logic   l0_en,
  input logic   l1_en,
  input logic   l2_en,
  input fp_op_t l0_op,
  input fp_op_t l1_op,
  input fp_op_t l2_op,
  input logic   l0_res_valid,
  input logic   l1_res_valid,
  input logic   l2_res_valid,
  input logic   cvt_valid
);

  logic cvt_issue;

  assign cvt_issue = l2_en && (l2_op == OP_CVT);

  property lane_latency(en, op, valid);
    @(posedge clk) disable iff (!rst_n) (en && op != OP_CVT) |=> valid;
  endproperty

  reset_valids_low: assert property (@(posedge clk)
    !rst_n |=> !(l0_res_valid || l1_res_valid || l2_res_valid || cvt_valid))
    else $error("Result valid high in the cycle after reset");

  lane0_latency: assert property (lane_latency(l0_en, l0_op, l0_res_valid))
    else $error("Lane 0 result valid missing one cycle after issue");
  lane1_latency: assert property (lane_latency(l1_en, l1_op, l1_res_valid))
    else $error("Lane 1 result valid missing one cycle after issue");
  lane2_latency: assert property (lane_latency(l2_en, l2_op, l2_res_valid))
    else $error("Lane 2 result valid missing one cycle after issue");

  cvt_latency: assert property (@(posedge clk) disable iff (!rst_n)
    cvt_issue |-> ##CVT_STAGES cvt_valid)
    else $error("Converter valid missing after convert issue");

  // Every converter valid traces back to an issue on lane 2
  cvt_no_spurious: assert property (@(posedge clk) disable iff (!rst_n)
    cvt_valid |-> $past(cvt_issue, CVT_STAGES))
    else $error("Converter valid without a matching issue");

endmodule

bind fpu_simd_cluster fpu_simd_cluster_sva #(
  .CVT_STAGES (CVT_STAGES)
) sva_i (
  .clk          (clk),
  .rst_n        (rst_n),
  .l0_en        (l0_en),
  .l1_en        (l1_en),
  .l2_en        (l2_en),
  .l0_op        (l0_op),
  .l1_op        (l1_op),
  .l2_op        (l2_op),
  .l0_res_valid (l0_res_valid),
  .l1_res_valid (l1_res_valid),
  .l2_res_valid (l2_res_valid),
  .cvt_valid    (cvt_valid)
);

// File: design/fpu_simd_cluster.sv
/*
  FPU SIMD cluster
  Three packed single lanes sharing a result forwarding bus, with lane 2
  feeding the float to int converter on the alternate result port.
*/
`timescale 1ns/1ps

module fpu_simd_cluster
  import fpu_ops_pkg::*;
  import fpu_data_pkg::*;
#(
  parameter int CVT_STAGES = 2
) (
  input  logic     clk,
  input  logic     rst_n,

  input  vec_t     l0_a,
  input  vec_t     l0_b,
  input  src_sel_t l0_src_a,
  input  src_sel_t l0_src_b,
  input  fp_op_t   l0_op,
  input  logic     l0_en,
  output vec_t     l0_res,
  output logic     l0_res_valid,

  input  vec_t     l1_a,
  input  vec_t     l1_b,
  input  src_sel_t l1_src_a,
  input  src_sel_t l1_src_b,
  input  fp_op_t   l1_op,
  input  logic     l1_en,
  output vec_t     l1_res,
  output logic     l1_res_valid,

  input  vec_t     l2_a,
  input  vec_t     l2_b,
  input  src_sel_t l2_src_a,
  input  src_sel_t l2_src_b,
  input  fp_op_t   l2_op,
  input  logic     l2_en,
  output vec_t     l2_res,
  output logic     l2_res_valid,

  output vec_t     cvt_res,
  output logic     cvt_valid
);

  logic cvt_issue;
  vec_t cvt_operand;

  ////////////////////////////////////////
  // Lanes, each held result goes onto the forwarding bus

  fp_simd_lane lane0_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .a           (l0_a),
    .b           (l0_b),
    .src_a       (l0_src_a),
    .src_b       (l0_src_b),
    .op          (l0_op),
    .en          (l0_en),
    .fwd0        (l0_res),
    .fwd1        (l1_res),
    .fwd2        (l2_res),
    .res         (l0_res),
    .res_valid   (l0_res_valid),
    .cvt_issue   (),
    .cvt_operand ()
  );

  fp_simd_lane lane1_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .a           (l1_a),
    .b           (l1_b),
    .src_a       (l1_src_a),
    .src_b       (l1_src_b),
    .op          (l1_op),
    .en          (l1_en),
    .fwd0        (l0_res),
    .fwd1        (l1_res),
    .fwd2        (l2_res),
    .res         (l1_res),
    .res_valid   (l1_res_valid),
    .cvt_issue   (),
    .cvt_operand ()
  );

  fp_simd_lane lane2_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .a           (l2_a),
    .b           (l2_b),
    .src_a       (l2_src_a),
    .src_b       (l2_src_b),
    .op          (l2_op),
    .en          (l2_en),
    .fwd0        (l0_res),
    .fwd1        (l1_res),
    .fwd2        (l2_res),
    .res         (l2_res),
    .res_valid   (l2_res_valid),
    .cvt_issue   (cvt_issue),
    .cvt_operand (cvt_operand)
  );

  ////////////////////////////////////////
  // Alternate result path

  fp_to_int_cvt #(
    .CVT_STAGES (CVT_STAGES)
  ) cvt_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (cvt_issue),
    .operand   (cvt_operand),
    .out_valid (cvt_valid),
    .result    (cvt_res)
  );

endmodule

// File: design/fp_to_int_cvt.sv
/*
  Packed single to int32 converter
  Truncates toward zero, saturates out of range values, NaN and denormals
  give zero. Latency is CVT_STAGES cycles with one issue per cycle.
*/
`timescale 1ns/1ps

module fp_to_int_cvt
  import fpu_data_pkg::*;
#(
  parameter int CVT_STAGES = 2
) (
  input  logic clk,
  input  logic rst_n,
  input  logic in_valid,
  input  vec_t operand,
  output logic out_valid,
  output vec_t result
);

  typedef logic [1:0] cls_t;

  localparam cls_t CLS_ZERO = 2'd0;
  localparam cls_t CLS_NAN  = 2'd1;
  localparam cls_t CLS_SAT  = 2'd2;
  localparam cls_t CLS_NORM = 2'd3;

  // Largest exponent whose magnitude still fits below 2^31
  localparam int EXP_TOP = EXP_BIAS + 30;

  logic s1_valid;
  vec_t conv;

  ////////////////////////////////////////
  // Per element classify and convert

  for (genvar e = 0; e < 2; e++) begin : g_elem
    single_t     x;
    logic [7:0]  exp_f;
    cls_t        cls_d;
    logic        s1_sign;
    cls_t        s1_cls;
    logic [4:0]  s1_shift;
    logic [23:0] s1_man;
    logic [53:0] wide;
    logic [30:0] mag;
    int32_t      val;

    assign x     = operand[32*e +: 32];
    assign exp_f = x[30:23];

    // Below one and denormals all truncate to zero
    always_comb begin
      if (exp_f == 8'hFF && x[22:0] != '0)
        cls_d = CLS_NAN;
      else if (exp_f > EXP_TOP)
        cls_d = CLS_SAT;
      else if (exp_f < EXP_BIAS)
        cls_d = CLS_ZERO;
      else
        cls_d = CLS_NORM;
    end

    always_ff @(posedge clk) begin
      s1_sign  <= x[31];
      s1_cls   <= cls_d;
      s1_shift <= 5'(exp_f - EXP_BIAS);
      s1_man   <= {1'b1, x[22:0]};
    end

    // Binary point sits at bit 23 of the shifted mantissa
    assign wide = {30'b0, s1_man} << s1_shift;
    assign mag  = wide[53:23];

    always_comb begin
      case (s1_cls)
        CLS_SAT:  val = s1_sign ? INT_MIN_C : INT_MAX_C;
        CLS_NORM: begin
          val = {1'b0, mag};
          if (s1_sign)
            val = -val;
        end
        default:  val = '0;
      endcase
    end

    assign conv[32*e +: 32] = val;
  end

  always_ff @(posedge clk) begin
    if (!rst_n)
      s1_valid <= 1'b0;
    else
      s1_valid <= in_valid;
  end

  ////////////////////////////////////////
  // Output delay stages

  if (CVT_STAGES == 1) begin : g_direct
    assign result    = conv;
    assign out_valid = s1_valid;
  end else begin : g_delay
    vec_t                  data_q [CVT_STAGES-1];
    logic [CVT_STAGES-2:0] valid_q;

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        valid_q <= '0;
      end else begin
        valid_q[0] <= s1_valid;
        for (int i = 1; i < CVT_STAGES - 1; i++) begin
          valid_q[i] <= valid_q[i-1];
        end
      end
    end

    always_ff @(posedge clk) begin
      data_q[0] <= conv;
      for (int i = 1; i < CVT_STAGES - 1; i++) begin
        data_q[i] <= data_q[i-1];
      end
    end

    assign result    = data_q[CVT_STAGES-2];
    assign out_valid = valid_q[CVT_STAGES-2];
  end

endmodule

// File: design/fp_simd_lane.sv
/*
  FP SIMD lane
  Packed single lane with operand forwarding, logic, min/max and sign ops.
  Results are held in a register that also feeds the forwarding bus.
  Convert requests leave the lane combinationally toward the converter.
*/
`timescale 1ns/1ps

module fp_simd_lane
  import fpu_ops_pkg::*;
  import fpu_data_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  vec_t     a,
  input  vec_t     b,
  input  src_sel_t src_a,
  input  src_sel_t src_b,
  input  fp_op_t   op,
  input  logic     en,
  input  vec_t     fwd0,
  input  vec_t     fwd1,
  input  vec_t     fwd2,
  output vec_t     res,
  output logic     res_valid,
  output logic     cvt_issue,
  output vec_t     cvt_operand
);

  vec_t opa;
  vec_t opb;
  vec_t alu_out;
  logic alu_issue;

  ////////////////////////////////////////
  // Helpers

  function automatic vec_t pick_src(src_sel_t sel, vec_t port, vec_t f0, vec_t f1, vec_t f2);
    vec_t v;
    case (sel)
      SRC_PORT:  v = port;
      SRC_LANE0: v = f0;
      SRC_LANE1: v = f1;
      SRC_LANE2: v = f2;
      default:   v = port;
    endcase
    return v;
  endfunction

  // Unsigned key in sign-magnitude order, NaN patterns included
  function automatic logic [31:0] order_key(single_t x);
    logic [31:0] k;
    if (x[31])
      k = ~x;
    else
      k = {1'b1, x[30:0]};
    return k;
  endfunction

  function automatic single_t elem_op(fp_op_t f, single_t x, single_t y);
    logic    a_le_b;
    logic    a_ge_b;
    single_t r;
    a_le_b = order_key(x) <= order_key(y);
    a_ge_b = order_key(x) >= order_key(y);
    case (f)
      OP_MIN:  r = a_le_b ? x : y;
      OP_MAX:  r = a_ge_b ? x : y;
      OP_NEG:  r = {~x[31], x[30:0]};
      OP_ABS:  r = {1'b0, x[30:0]};
      default: r = x;
    endcase
    return r;
  endfunction

  ////////////////////////////////////////
  // Operand select and execute

  // Forwarded values are the held results before this edge
  assign opa = pick_src(src_a, a, fwd0, fwd1, fwd2);
  assign opb = pick_src(src_b, b, fwd0, fwd1, fwd2);

  always_comb begin
    case (op)
      OP_AND:  alu_out = opa & opb;
      OP_OR:   alu_out = opa | opb;
      OP_XOR:  alu_out = opa ^ opb;
      OP_ANDN: alu_out = opa & ~opb;
      default: alu_out = {elem_op(op, opa[63:32], opb[63:32]),
                          elem_op(op, opa[31:0], opb[31:0])};
    endcase
  end

  assign alu_issue = en && (op != OP_CVT);

  // Convert goes out in the issue cycle, only lane 2's port is wired up
  assign cvt_issue   = en && (op == OP_CVT);
  assign cvt_operand = opa;

  ////////////////////////////////////////
  // Held result

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res       <= '0;
      res_valid <= 1'b0;
    end else begin
      res_valid <= alu_issue;
      if (alu_issue) begin
        res <= alu_out;
      end
    end
  end

endmodule

// File: design/fpu_data_pkg.sv
/*
  FPU SIMD data types
  Packed pair and element widths, plus the int32 saturation limits
*/
package fpu_data_pkg;

  // Element 0 in bits 31..0, element 1 in bits 63..32
  typedef logic [63:0] vec_t;

  typedef logic [31:0] single_t;

  typedef logic signed [31:0] int32_t;

  // IEEE single exponent bias
  localparam int EXP_BIAS = 127;

  // Saturation values of the float to int conversion
  localparam int32_t INT_MAX_C = 32'sh7FFF_FFFF;
  localparam int32_t INT_MIN_C = 32'sh8000_0000;

endpackage

// File: design/fpu_ops_pkg.sv
/*
  FPU SIMD operation encodings
  Lane opcodes and operand source selects used by the lanes and the cluster
*/
package fpu_ops_pkg;

  // Lane opcodes
  typedef enum logic [3:0] {
    OP_AND  = 4'd0,
    OP_OR   = 4'd1,
    OP_XOR  = 4'd2,
    OP_ANDN = 4'd3,
    OP_MIN  = 4'd4,
    OP_MAX  = 4'd5,
    OP_NEG  = 4'd6,
    OP_ABS  = 4'd7,
    OP_CVT  = 4'd8
  } fp_op_t;

  // Picks the operand port or the held result of one lane
  typedef logic [1:0] src_sel_t;

  localparam src_sel_t SRC_PORT  = 2'd0;
  localparam src_sel_t SRC_LANE0 = 2'd1;
  localparam src_sel_t SRC_LANE1 = 2'd2;
  localparam src_sel_t SRC_LANE2 = 2'd3;

endpackage
